// File: design/mem_pkg.sv
package mem_pkg;

    // data and address word, instruction word, register index
    typedef logic [63:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    // one enable bit per byte lane of a doubleword
    typedef logic [7:0]  byte_mask_t;

    // operation carried into the memory stage
    typedef enum logic [4:0] {
        op_none = 5'd0,
        op_alu  = 5'd1,
        // signed loads
        op_lb   = 5'd2,
        op_lh   = 5'd3,
        op_lw   = 5'd4,
        // unsigned loads
        op_lbu  = 5'd5,
        op_lhu  = 5'd6,
        op_lwu  = 5'd7,
        op_ld   = 5'd8,
        // stores
        op_sb   = 5'd9,
        op_sh   = 5'd10,
        op_sw   = 5'd11,
        op_sd   = 5'd12
    } mem_op_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_mode_t;

    // one issued operation from the previous stage
    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        inst_t     inst;
        mem_op_t   op;
        xlen_t     operand_a;
        xlen_t     operand_b;
        alu_mode_t alu_mode;
        reg_idx_t  rd;
        xlen_t     store_data;
    } ex_issue_t;

    // stage result toward writeback
    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        inst_t    inst;
        logic     reg_wen;
        reg_idx_t rd;
        xlen_t    value;
    } wb_t;

endpackage

// File: design/exec_alu.sv
`timescale 1ns/100ps

module exec_alu (
    input  mem_pkg::xlen_t     operand_a,
    input  mem_pkg::xlen_t     operand_b,
    input  mem_pkg::alu_mode_t mode,
    output mem_pkg::xlen_t     result
);

    // shift amount is the low six bits of b
    logic [5:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt = operand_b[5:0];

    // compare results, used by slt and sltu
    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    // **********************************************************
    // function select
    // **********************************************************
    always_comb begin
        case (mode)
            mem_pkg::alu_add: begin
                result = operand_a + operand_b;
            end
            mem_pkg::alu_sub: begin
                result = operand_a - operand_b;
            end
            mem_pkg::alu_and: begin
                result = operand_a & operand_b;
            end
            mem_pkg::alu_or: begin
                result = operand_a | operand_b;
            end
            mem_pkg::alu_xor: begin
                result = operand_a ^ operand_b;
            end
            // logical shifts
            mem_pkg::alu_sll: begin
                result = operand_a << shamt;
            end
            mem_pkg::alu_srl: begin
                result = operand_a >> shamt;
            end
            // arithmetic shift keeps the sign
            mem_pkg::alu_sra: begin
                result = mem_pkg::xlen_t'($signed(operand_a) >>> shamt);
            end
            // set-less-than gives 1 or 0
            mem_pkg::alu_slt: begin
                result = {63'd0, lt_signed};
            end
            mem_pkg::alu_sltu: begin
                result = {63'd0, lt_unsigned};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: design/store_align.sv
`timescale 1ns/100ps

module store_align (
    input  mem_pkg::mem_op_t    op,
    input  logic [2:0]          byte_offset,
    input  mem_pkg::xlen_t      store_data,
    output mem_pkg::xlen_t      wdata,
    output mem_pkg::byte_mask_t wmask
);

    // bit shift for the addressed lane
    logic [5:0] bit_shift;

    assign bit_shift = {byte_offset, 3'b000};

    // **********************************************************
    // lane placement and byte mask
    // **********************************************************
    always_comb begin
        wdata = '0;
        wmask = '0;
        case (op)
            // byte goes to any lane
            mem_pkg::op_sb: begin
                wdata = {56'd0, store_data[7:0]} << bit_shift;
                wmask = 8'h01 << byte_offset;
            end
            // half at offset 7 would cross the doubleword, dropped
            mem_pkg::op_sh: begin
                if (byte_offset != 3'd7) begin
                    wdata = {48'd0, store_data[15:0]} << bit_shift;
                    wmask = 8'h03 << byte_offset;
                end
            end
            // word picks the upper or lower half by bit 2 only
            mem_pkg::op_sw: begin
                if (byte_offset[2]) begin
                    wdata = {store_data[31:0], 32'd0};
                    wmask = 8'hf0;
                end else begin
                    wdata = {32'd0, store_data[31:0]};
                    wmask = 8'h0f;
                end
            end
            mem_pkg::op_sd: begin
                wdata = store_data;
                wmask = 8'hff;
            end
            // loads, alu and none write nothing
            default: begin
                wdata = '0;
                wmask = '0;
            end
        endcase
    end

endmodule

// File: design/load_extract.sv
`timescale 1ns/100ps

module load_extract (
    input  mem_pkg::mem_op_t op,
    input  logic [2:0]       byte_offset,
    input  mem_pkg::xlen_t   rdata,
    output mem_pkg::xlen_t   value
);

    // read word moved down so the addressed lane sits at bit 0
    mem_pkg::xlen_t lane;
    logic [7:0]     lane_byte;
    logic [15:0]    lane_half;
    logic [31:0]    lane_word;
    logic           half_ok;

    assign lane      = rdata >> {byte_offset, 3'b000};
    assign lane_byte = lane[7:0];
    assign lane_half = lane[15:0];
    // words only look at offset bit 2
    assign lane_word = byte_offset[2] ? rdata[63:32] : rdata[31:0];
    // half at the last byte has no second byte in this word
    assign half_ok   = byte_offset != 3'd7;

    // **********************************************************
    // extension per op
    // **********************************************************
    always_comb begin
        case (op)
            mem_pkg::op_lb: begin
                value = {{56{lane_byte[7]}}, lane_byte};
            end
            mem_pkg::op_lbu: begin
                value = {56'd0, lane_byte};
            end
            mem_pkg::op_lh: begin
                value = half_ok ? {{48{lane_half[15]}}, lane_half} : '0;
            end
            mem_pkg::op_lhu: begin
                value = half_ok ? {48'd0, lane_half} : '0;
            end
            mem_pkg::op_lw: begin
                value = {{32{lane_word[31]}}, lane_word};
            end
            mem_pkg::op_lwu: begin
                value = {32'd0, lane_word};
            end
            // doubleword as read
            mem_pkg::op_ld: begin
                value = rdata;
            end
            default: begin
                value = '0;
            end
        endcase
    end

endmodule

// File: design/data_ram.sv
`timescale 1ns/100ps

module data_ram #(
    parameter int ram_depth = 512
) (
    input  logic                         clk,
    input  logic                         wr_en,
    input  logic [$clog2(ram_depth)-1:0] wr_index,
    input  mem_pkg::xlen_t               wr_data,
    input  mem_pkg::byte_mask_t          wr_mask,
    input  logic [$clog2(ram_depth)-1:0] rd_index,
    output mem_pkg::xlen_t               rd_data
);

    // doubleword storage, contents undefined after power-up
    mem_pkg::xlen_t mem [ram_depth];

    // **********************************************************
    // write port
    // **********************************************************
    // per-byte enables
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 8; i++) begin
                if (wr_mask[i]) begin
                    mem[wr_index][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // **********************************************************
    // read port
    // **********************************************************
    // combinational, sees a write only after its edge
    assign rd_data = mem[rd_index];

endmodule

// File: design/mem_stage.sv
`timescale 1ns/100ps

module mem_stage #(
    parameter int ram_depth = 512
) (
    input  logic                         clk,
    input  logic                         rst,
    input  mem_pkg::ex_issue_t           issue,
    output mem_pkg::wb_t                 wb,
    output logic                         wr_en,
    output logic [$clog2(ram_depth)-1:0] wr_index,
    output mem_pkg::xlen_t               wr_data,
    output mem_pkg::byte_mask_t          wr_mask,
    output logic [$clog2(ram_depth)-1:0] rd_index,
    input  mem_pkg::xlen_t               rd_data
);

    localparam int idx_w = $clog2(ram_depth);

    // stage register and its qualified views
    mem_pkg::ex_issue_t ex_reg;
    mem_pkg::mem_op_t   op_q;
    mem_pkg::xlen_t     alu_result;
    mem_pkg::xlen_t     addr;
    mem_pkg::xlen_t     load_value;
    logic               is_load;
    logic               is_store;
    logic               rf_write;

    // **********************************************************
    // stage register
    // **********************************************************
    // one cycle, no stall
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_reg <= '0;
        end else begin
            ex_reg <= issue;
        end
    end

    // op only counts while the entry is valid
    assign op_q = ex_reg.valid ? ex_reg.op : mem_pkg::op_none;

    // **********************************************************
    // execute
    // **********************************************************
    exec_alu u_alu (
        .operand_a (ex_reg.operand_a),
        .operand_b (ex_reg.operand_b),
        .mode      (ex_reg.alu_mode),
        .result    (alu_result)
    );

    // op class decode
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (op_q)
            mem_pkg::op_lb, mem_pkg::op_lh, mem_pkg::op_lw,
            mem_pkg::op_lbu, mem_pkg::op_lhu, mem_pkg::op_lwu,
            mem_pkg::op_ld: begin
                is_load = 1'b1;
            end
            mem_pkg::op_sb, mem_pkg::op_sh, mem_pkg::op_sw,
            mem_pkg::op_sd: begin
                is_store = 1'b1;
            end
            default: begin
                is_load  = 1'b0;
                is_store = 1'b0;
            end
        endcase
    end

    // byte address, zero unless a memory op
    assign addr = (is_load || is_store) ? alu_result : '0;

    // **********************************************************
    // memory access
    // **********************************************************
    store_align u_store (
        .op          (op_q),
        .byte_offset (addr[2:0]),
        .store_data  (ex_reg.store_data),
        .wdata       (wr_data),
        .wmask       (wr_mask)
    );

    // doubleword index wraps at the depth
    assign wr_index = addr[idx_w+2:3];
    assign rd_index = addr[idx_w+2:3];
    // empty mask means nothing to write, e.g. half at offset 7
    assign wr_en    = is_store && (wr_mask != '0);

    load_extract u_load (
        .op          (op_q),
        .byte_offset (addr[2:0]),
        .rdata       (rd_data),
        .value       (load_value)
    );

    // **********************************************************
    // writeback
    // **********************************************************
    // x0 is never written
    assign rf_write = (op_q == mem_pkg::op_alu || is_load) && (ex_reg.rd != '0);

    always_comb begin
        wb         = '0;
        wb.valid   = ex_reg.valid;
        wb.pc      = ex_reg.pc;
        wb.inst    = ex_reg.inst;
        wb.reg_wen = rf_write;
        wb.rd      = ex_reg.valid ? ex_reg.rd : '0;
        // value stays zero without a register write
        if (rf_write) begin
            wb.value = is_load ? load_value : alu_result;
        end
    end

endmodule

// File: design/mem_top.sv
`timescale 1ns/100ps

module mem_top #(
    parameter int ram_depth = 512
) (
    input  logic               clk,
    input  logic               rst,
    input  mem_pkg::ex_issue_t issue,
    output mem_pkg::wb_t       wb
);

    // stage to ram
    logic                         wr_en;
    logic [$clog2(ram_depth)-1:0] wr_index;
    mem_pkg::xlen_t               wr_data;
    mem_pkg::byte_mask_t          wr_mask;
    logic [$clog2(ram_depth)-1:0] rd_index;
    // ram to stage, same cycle
    mem_pkg::xlen_t               rd_data;

    mem_stage #(
        .ram_depth (ram_depth)
    ) u_stage (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .wb       (wb),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_mask  (wr_mask),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

    data_ram #(
        .ram_depth (ram_depth)
    ) u_ram (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_mask  (wr_mask),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

endmodule

// File: sim/mem_sva.sv
`timescale 1ns/100ps

module mem_sva (
    input logic               clk,
    input logic               rst,
    input mem_pkg::wb_t       wb,
    input logic               wr_en,
    input mem_pkg::ex_issue_t ex_reg
);

    // registered entry is a live store
    logic store_q;
    // number of assertion failures so far
    int   failures = 0;

    assign store_q = ex_reg.valid && (ex_reg.op inside {mem_pkg::op_sb, mem_pkg::op_sh,
                                                        mem_pkg::op_sw, mem_pkg::op_sd});

    // **********************************************************
    // stage control rules
    // **********************************************************
    // stage register clear right after a reset edge
    reset_clears: assert property (@(posedge clk) rst |=> (!wr_en && !wb.reg_wen))
        else begin
            $error("write enable or reg_wen high in the cycle after reset");
            failures++;
        end

    // no register write from an empty slot
    wen_needs_valid: assert property (@(posedge clk) disable iff (rst)
        wb.reg_wen |-> wb.valid)
        else begin
            $error("reg_wen high while wb.valid is low");
            failures++;
        end

    // ram only written by stores
    wr_only_store: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> store_q)
        else begin
            $error("ram write enable high without a valid store");
            failures++;
        end

    // stores have no destination register
    store_no_wen: assert property (@(posedge clk) disable iff (rst)
        store_q |-> !wb.reg_wen)
        else begin
            $error("store raised reg_wen");
            failures++;
        end

endmodule

bind mem_stage mem_sva u_sva (
    .clk    (clk),
    .rst    (rst),
    .wb     (wb),
    .wr_en  (wr_en),
    .ex_reg (ex_reg)
);

// File: sim/mem_tb.sv
`timescale 1ns/100ps

module mem_tb;

    localparam int ram_depth    = 512;
    localparam int shadow_bytes = ram_depth * 8;
    localparam int addr_w       = $clog2(shadow_bytes);
    localparam int max_cycles   = 2000;
    // doubleword window used by the memory tests
    localparam int win_base     = 'h540;
    localparam int win_dwords   = 32;

    logic               clk = 1'b0;
    logic               rst;
    mem_pkg::ex_issue_t issue;
    mem_pkg::wb_t       wb;

    // byte image of the ram
    logic [7:0]         shadow [shadow_bytes];
    // expected results waiting for their wb cycle
    mem_pkg::wb_t       exp_q [$];
    bit                 rb_q [$];
    // doubleword the shadow holds at each readback address
    mem_pkg::xlen_t     rb_val_q [$];
    mem_pkg::wb_t       cur_exp;
    bit                 cur_rb;
    mem_pkg::xlen_t     cur_rb_val;
    int                 errors      = 0;
    int                 checks      = 0;
    int                 cycle_count = 0;

    mem_top #(
        .ram_depth (ram_depth)
    ) dut0 (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .wb    (wb)
    );

    always #50 clk = ~clk;

    // **********************************************************
    // reference model
    // **********************************************************
    function automatic bit is_load(input mem_pkg::mem_op_t op);
        return op inside {mem_pkg::op_lb, mem_pkg::op_lh, mem_pkg::op_lw, mem_pkg::op_lbu,
                          mem_pkg::op_lhu, mem_pkg::op_lwu, mem_pkg::op_ld};
    endfunction

    function automatic mem_pkg::xlen_t ref_alu(input mem_pkg::xlen_t a, input mem_pkg::xlen_t b,
                                               input mem_pkg::alu_mode_t mode);
        mem_pkg::xlen_t fill;
        int             sh;
        sh   = int'(b[5:0]);
        // sign bits that enter from the top on sra
        fill = a[63] ? ~(~64'd0 >> sh) : 64'd0;
        case (mode)
            mem_pkg::alu_add:  return a + b;
            mem_pkg::alu_sub:  return a - b;
            mem_pkg::alu_and:  return a & b;
            mem_pkg::alu_or:   return a | b;
            mem_pkg::alu_xor:  return a ^ b;
            mem_pkg::alu_sll:  return a << sh;
            mem_pkg::alu_srl:  return a >> sh;
            mem_pkg::alu_sra:  return (a >> sh) | fill;
            mem_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            mem_pkg::alu_sltu: return (a < b) ? 64'd1 : 64'd0;
            default:           return '0;
        endcase
    endfunction

    function automatic mem_pkg::wb_t ref_wb(input mem_pkg::ex_issue_t it,
                                            input logic [7:0] img [shadow_bytes]);
        mem_pkg::wb_t       exp;
        mem_pkg::xlen_t     res;
        mem_pkg::xlen_t     dw;
        mem_pkg::xlen_t     lane;
        logic signed [63:0] ext;
        logic [addr_w-1:0]  base;
        logic [2:0]         off;
        logic               load;
        res  = ref_alu(it.operand_a, it.operand_b, it.alu_mode);
        off  = res[2:0];
        base = {res[addr_w-1:3], 3'b000};
        // doubleword around the address, little endian
        for (int i = 0; i < 8; i++) begin
            dw[8*i +: 8] = img[base + i];
        end
        lane = dw >> (8 * off);
        load = is_load(it.op);
        case (it.op)
            mem_pkg::op_lb:  ext = $signed(lane[7:0]);
            mem_pkg::op_lbu: ext = {56'd0, lane[7:0]};
            mem_pkg::op_lh:  ext = (off != 3'd7) ? $signed(lane[15:0]) : 64'sd0;
            mem_pkg::op_lhu: ext = (off != 3'd7) ? {48'd0, lane[15:0]} : 64'd0;
            // word half picked by offset bit 2
            mem_pkg::op_lw:  ext = $signed(off[2] ? dw[63:32] : dw[31:0]);
            mem_pkg::op_lwu: ext = {32'd0, off[2] ? dw[63:32] : dw[31:0]};
            mem_pkg::op_ld:  ext = dw;
            default:         ext = '0;
        endcase
        exp         = '0;
        exp.valid   = it.valid;
        exp.pc      = it.pc;
        exp.inst    = it.inst;
        exp.rd      = it.valid ? it.rd : '0;
        exp.reg_wen = it.valid && (it.op == mem_pkg::op_alu || load) && (it.rd != '0);
        if (exp.reg_wen) begin
            exp.value = load ? mem_pkg::xlen_t'(ext) : res;
        end
        return exp;
    endfunction

    // aligned doubleword of the shadow image around a byte address
    function automatic mem_pkg::xlen_t shadow_dword(input mem_pkg::xlen_t addr);
        mem_pkg::xlen_t    dw;
        logic [addr_w-1:0] base;
        base = {addr[addr_w-1:3], 3'b000};
        for (int i = 0; i < 8; i++) begin
            dw[8*i +: 8] = shadow[base + i];
        end
        return dw;
    endfunction

    // store bytes into the shadow image
    task automatic apply_store(input mem_pkg::ex_issue_t it);
        mem_pkg::xlen_t    res;
        logic [addr_w-1:0] a;
        int                nbytes;
        res    = ref_alu(it.operand_a, it.operand_b, it.alu_mode);
        a      = res[addr_w-1:0];
        nbytes = 0;
        if (it.valid) begin
            case (it.op)
                mem_pkg::op_sb: nbytes = 1;
                // half at the last lane is dropped
                mem_pkg::op_sh: nbytes = (a[2:0] == 3'd7) ? 0 : 2;
                mem_pkg::op_sw: nbytes = 4;
                mem_pkg::op_sd: nbytes = 8;
                default:        nbytes = 0;
            endcase
        end
        if (it.op == mem_pkg::op_sw) begin
            a[1:0] = 2'b00;
        end
        if (it.op == mem_pkg::op_sd) begin
            a[2:0] = 3'b000;
        end
        for (int i = 0; i < nbytes; i++) begin
            shadow[a + i] = it.store_data[8*i +: 8];
        end
    endtask

    // **********************************************************
    // checks
    // **********************************************************
    task automatic check_wb(input mem_pkg::wb_t got, input mem_pkg::wb_t exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_value(input mem_pkg::xlen_t got, input mem_pkg::xlen_t exp,
                               input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // result sampled mid-cycle, one cycle after its issue
    always @(posedge clk) begin
        if (exp_q.size() > 0) begin
            cur_exp    = exp_q.pop_front();
            cur_rb     = rb_q.pop_front();
            cur_rb_val = rb_val_q.pop_front();
            @(negedge clk);
            check_wb(wb, cur_exp, "wb");
            if (cur_rb) begin
                check_value(wb.value, cur_rb_val, "wb.value");
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout after %0d cycles, stimulus did not complete", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // **********************************************************
    // stimulus
    // **********************************************************
    function automatic mem_pkg::ex_issue_t rand_issue(input mem_pkg::mem_op_t op);
        mem_pkg::ex_issue_t it;
        it.valid      = 1'b1;
        it.pc         = {$urandom, $urandom};
        it.inst       = $urandom;
        it.op         = op;
        it.operand_a  = {$urandom, $urandom};
        it.operand_b  = {$urandom, $urandom};
        it.alu_mode   = mem_pkg::alu_mode_t'($urandom_range(9, 0));
        it.rd         = mem_pkg::reg_idx_t'($urandom_range(31, 0));
        it.store_data = {$urandom, $urandom};
        return it;
    endfunction

    // address built as a + b, upper bits random
    function automatic mem_pkg::ex_issue_t at_addr(input mem_pkg::mem_op_t op, input int addr);
        mem_pkg::ex_issue_t it;
        mem_pkg::xlen_t     full;
        mem_pkg::xlen_t     split;
        it                = rand_issue(op);
        full              = {$urandom, $urandom};
        full[addr_w-1:0]  = addr[addr_w-1:0];
        split             = mem_pkg::xlen_t'($urandom_range(4095, 0));
        it.operand_a      = full - split;
        it.operand_b      = split;
        it.alu_mode       = mem_pkg::alu_add;
        return it;
    endfunction

    // drive on the falling edge, then wait one cycle
    task automatic send(input mem_pkg::ex_issue_t it, input bit readback);
        // readback needs a destination, x0 would hide the value
        if (readback && it.rd == '0) begin
            it.rd = 5'd1;
        end
        issue = it;
        exp_q.push_back(ref_wb(it, shadow));
        rb_q.push_back(readback);
        rb_val_q.push_back(shadow_dword(ref_alu(it.operand_a, it.operand_b, it.alu_mode)));
        apply_store(it);
        @(negedge clk);
    endtask

    initial begin
        mem_pkg::ex_issue_t it;
        int                 addr;
        void'($urandom(35571));
        rst   = 1'b1;
        issue = '0;
        // quiet stage through reset and after
        repeat (10) begin
            @(negedge clk);
            check_wb(wb, '0, "wb");
        end
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_wb(wb, '0, "wb");
        end
        // known contents for the test window
        for (int d = 0; d < win_dwords; d++) begin
            send(at_addr(mem_pkg::op_sd, win_base + 8 * d), 1'b0);
        end
        // alu over all modes, small shifts and x0 now and then
        for (int n = 0; n < 300; n++) begin
            it          = rand_issue(mem_pkg::op_alu);
            it.alu_mode = mem_pkg::alu_mode_t'(n % 10);
            if (n % 7 == 0) begin
                it.operand_b = mem_pkg::xlen_t'($urandom_range(63, 0));
            end
            if (n % 9 == 0) begin
                it.rd = '0;
            end
            send(it, 1'b0);
        end
        // each store width at each offset, read back as doubleword
        for (int s = int'(mem_pkg::op_sb); s <= int'(mem_pkg::op_sd); s++) begin
            for (int off = 0; off < 8; off++) begin
                repeat (2) begin
                    addr = win_base + 8 * int'($urandom_range(win_dwords - 1, 0)) + off;
                    send(at_addr(mem_pkg::mem_op_t'(s), addr), 1'b0);
                    send(at_addr(mem_pkg::op_ld, addr - off), 1'b1);
                end
            end
        end
        // each load at each offset
        for (int l = int'(mem_pkg::op_lb); l <= int'(mem_pkg::op_ld); l++) begin
            for (int off = 0; off < 8; off++) begin
                repeat (3) begin
                    addr = win_base + 8 * int'($urandom_range(win_dwords - 1, 0)) + off;
                    send(at_addr(mem_pkg::mem_op_t'(l), addr), 1'b0);
                end
            end
        end
        // empty slots and op_none leave memory alone
        for (int n = 0; n < 20; n++) begin
            addr     = win_base + 8 * int'($urandom_range(win_dwords - 1, 0));
            it       = at_addr(mem_pkg::mem_op_t'($urandom_range(12, 2)), addr + n % 8);
            it.valid = 1'b0;
            send(it, 1'b0);
            send(at_addr(mem_pkg::op_none, addr), 1'b0);
            send(at_addr(mem_pkg::op_ld, addr), 1'b1);
        end
        // back-to-back loads and stores in four doublewords
        for (int n = 0; n < 600; n++) begin
            addr = win_base + int'($urandom_range(31, 0));
            send(at_addr(mem_pkg::mem_op_t'($urandom_range(12, 2)), addr), 1'b0);
        end
        issue = '0;
        repeat (2) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("run ended with %0d results never compared", exp_q.size());
            errors++;
        end
        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 checks, errors, dut0.u_stage.u_sva.failures);
        if (errors == 0 && dut0.u_stage.u_sva.failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
design/mem_pkg.sv
design/exec_alu.sv
design/store_align.sv
design/load_extract.sv
design/data_ram.sv
design/mem_stage.sv
design/mem_top.sv
sim/mem_sva.sv
sim/mem_tb.sv
